// File: hdl/microPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Microword format, field encodings and fixed microaddresses
// shared by the control store, sequencer and ALU datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package microPkg;

        localparam int dataW = 8;                       // Datapath word width
        localparam int opW = 4;                         // Opcode width

        localparam logic [7:0] addrIdle = 8'h0D;        // Wait for a command
        localparam logic [7:0] addrFetch = 8'h0E;       // Opcode dispatch
        localparam logic [7:0] addrWaitOut = 8'h0F;     // Shared wait for unknown opcodes

        localparam logic srcTemp = 1'b0;                // ALU input from temp register
        localparam logic srcInput = 1'b1;               // ALU input from operand register

        // Sequencer operations, reference BOP codes
        typedef enum logic [3:0] {
                seqIfZero    = 4'b0000,                 // Jump when ALU output is zero
                seqWaitCmd   = 4'b0100,                 // Hold until command accepted
                seqCount     = 4'b0110,                 // Next address
                seqIfNotZero = 4'b1000,                 // Jump when ALU output nonzero
                seqWaitOut   = 4'b1100,                 // Hold until result taken
                seqBranch    = 4'b1110,                 // Unconditional jump
                seqOpcode    = 4'b1111                  // Jump to opcode slot
        } branchOpE;

        // ALU functions, 181-style codes
        typedef enum logic [4:0] {
                funcOnes    = 5'b11100,                 // All ones
                funcZero    = 5'b10011,                 // All zeros
                funcAPlusB  = 5'b01001,                 // A plus B plus carry
                funcAMinusB = 5'b00110,                 // A plus not B plus carry
                funcAMinus1 = 5'b01111,                 // A minus 1 plus carry
                funcPassB   = 5'b11010                  // B straight through
        } aluFuncE;

        // Register write targets
        typedef enum logic [2:0] {
                destResult   = 3'b011,                  // Result register
                destBothTemp = 3'b100,                  // Temp A and temp B
                destTempB    = 3'b101,
                destTempA    = 3'b110,
                destNone     = 3'b111                   // No write
        } aluDestE;

        // One 24-bit microword, MSB first
        typedef struct packed {
                aluDestE    aluDest;                    // [23:21]
                logic       cin;                        // [20]
                aluFuncE    aluFunc;                    // [19:15]
                logic       bSource;                    // [14]
                logic       aSource;                    // [13]
                branchOpE   bop;                        // [12:9]
                logic       count;                      // [8] Step when not loading
                logic [7:0] nextAddr;                   // [7:0] Branch target
        } microWordT;

endpackage

// File: hdl/controlStore.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Microcode table, 256 words of 24 bits, read combinationally
// Holds idle, fetch, add, subtract and multiply routines
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module controlStore (
        input  logic [7:0]          microAddr,          // Current microaddress
        output microPkg::microWordT uWord               // Microword at that address
);
        import microPkg::*;

        always_comb begin
                // Quiet word, rows below override what they need
                uWord.aluDest = destNone;
                uWord.cin = 1'b0;                       // No carry
                uWord.aluFunc = funcOnes;
                uWord.bSource = srcInput;
                uWord.aSource = srcInput;
                uWord.bop = seqCount;
                uWord.count = 1'b1;                     // Count if no load
                uWord.nextAddr = 8'h00;

                case (microAddr)

                        // Idle and dispatch
                        addrIdle: begin
                                uWord.bop = seqWaitCmd;         // inReady high here
                                uWord.nextAddr = addrFetch;
                        end
                        addrFetch: begin
                                uWord.bop = seqOpcode;
                                uWord.nextAddr = 8'hF1;         // Low nibble gives slot X1
                        end
                        addrWaitOut: begin                      // Unknown opcode result
                                uWord.bop = seqWaitOut;
                                uWord.nextAddr = addrIdle;
                        end

                        // Opcode 3, ADD
                        8'h31: begin
                                uWord.aluDest = destResult;
                                uWord.aluFunc = funcAPlusB;     // Input A plus input B
                        end
                        8'h32: begin
                                uWord.bop = seqWaitOut;         // Hold until taken
                                uWord.nextAddr = addrIdle;
                        end

                        // Opcode 7, SUBTRACT
                        8'h71: begin
                                uWord.aluDest = destResult;
                                uWord.cin = 1'b1;               // Needed for two's complement
                                uWord.aluFunc = funcAMinusB;
                        end
                        8'h72: begin
                                uWord.bop = seqWaitOut;
                                uWord.nextAddr = addrIdle;
                        end

                        // Opcode 12, MULTIPLY by repeated addition
                        8'hC1: begin                            // Clear accumulator
                                uWord.aluDest = destTempB;
                                uWord.aluFunc = funcZero;
                        end
                        8'hC2: begin                            // Loop count from input B
                                uWord.aluDest = destTempA;
                                uWord.aluFunc = funcPassB;
                                uWord.bSource = srcInput;
                                uWord.bop = seqIfZero;          // B of zero skips the loop
                                uWord.nextAddr = 8'hC6;         // Result already cleared
                        end
                        8'hC3: begin                            // Accumulate input A
                                uWord.aluDest = destTempB;
                                uWord.aluFunc = funcAPlusB;
                                uWord.aSource = srcInput;
                                uWord.bSource = srcTemp;
                        end
                        8'hC4: begin                            // Step the loop count
                                uWord.aluDest = destTempA;
                                uWord.aluFunc = funcAMinus1;    // No carry so A minus 1
                                uWord.aSource = srcTemp;
                                uWord.bop = seqIfNotZero;
                                uWord.nextAddr = 8'hC3;         // Loop back
                        end
                        8'hC5: begin                            // Accumulator to result
                                uWord.aluDest = destResult;
                                uWord.aluFunc = funcPassB;
                                uWord.bSource = srcTemp;
                        end
                        8'hC6: begin
                                uWord.bop = seqWaitOut;
                                uWord.nextAddr = addrIdle;
                        end

                        // Every unused slot, unknown opcodes land here
                        default: begin
                                uWord.aluDest = destResult;
                                uWord.aluFunc = funcOnes;       // Returns FF
                                uWord.bop = seqBranch;
                                uWord.nextAddr = addrWaitOut;
                        end

                endcase
        end

endmodule

// File: hdl/microSequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Microprogram counter and next-address logic
// Also owns the opcode register and both handshake outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module microSequencer (
        input  logic                       clk,
        input  logic                       arstN,
        input  logic                       inValid,     // Host offers a command
        input  logic [microPkg::opW-1:0]   inOpcode,
        input  logic                       outReady,    // Host takes the result
        input  logic                       aluZero,     // From datapath
        input  microPkg::microWordT        uWord,
        output logic [7:0]                 microAddr,
        output logic                       inReady,
        output logic                       outValid,
        output logic                       cmdTake      // Loads operand registers
);
        import microPkg::*;

        logic [opW-1:0] opcodeReg;                      // Opcode of command in flight
        logic [7:0]     stepAddr;                       // Fall-through address
        logic [7:0]     nextMicroAddr;

        // Handshakes come straight from the current microword
        assign inReady = (uWord.bop == seqWaitCmd);
        assign outValid = (uWord.bop == seqWaitOut);
        assign cmdTake = inValid & inReady;

        assign stepAddr = uWord.count ? microAddr + 8'd1 : microAddr;

        always_comb begin
                case (uWord.bop)
                        seqCount:     nextMicroAddr = stepAddr;
                        seqBranch:    nextMicroAddr = uWord.nextAddr;
                        seqWaitCmd:   nextMicroAddr = cmdTake ? uWord.nextAddr : microAddr;
                        seqWaitOut:   nextMicroAddr = outReady ? uWord.nextAddr : microAddr;
                        seqIfZero:    nextMicroAddr = aluZero ? uWord.nextAddr : stepAddr;
                        seqIfNotZero: nextMicroAddr = aluZero ? stepAddr : uWord.nextAddr;
                        seqOpcode:    nextMicroAddr = {opcodeReg, uWord.nextAddr[3:0]};
                        default:      nextMicroAddr = addrIdle;      // Unused BOP codes
                endcase
        end

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        microAddr <= addrIdle;          // Wait for first command
                end else begin
                        microAddr <= nextMicroAddr;
                end
        end

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        opcodeReg <= '0;
                end else if (cmdTake) begin
                        opcodeReg <= inOpcode;          // Used at fetch
                end
        end

endmodule

// File: hdl/aluDatapath.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand, temp and result registers around an 8-bit ALU
// Sources, function and write target come from the microword
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module aluDatapath (
        input  logic                         clk,
        input  logic                         arstN,
        input  logic                         cmdTake,   // Command accepted this edge
        input  logic [microPkg::dataW-1:0]   inA,
        input  logic [microPkg::dataW-1:0]   inB,
        input  microPkg::microWordT          uWord,
        output logic                         aluZero,   // ALU output is zero
        output logic [microPkg::dataW-1:0]   outData
);
        import microPkg::*;

        logic [dataW-1:0] opA;                          // Operand registers
        logic [dataW-1:0] opB;
        logic [dataW-1:0] tempA;                        // Loop counter in multiply
        logic [dataW-1:0] tempB;                        // Accumulator in multiply
        logic [dataW-1:0] resultReg;
        logic [dataW-1:0] aluA;
        logic [dataW-1:0] aluB;
        logic [dataW-1:0] carryIn;
        logic [dataW-1:0] aluOut;

        // ALU input muxes
        assign aluA = (uWord.aSource == srcInput) ? opA : tempA;
        assign aluB = (uWord.bSource == srcInput) ? opB : tempB;
        assign carryIn = dataW'(uWord.cin);

        always_comb begin
                case (uWord.aluFunc)
                        funcOnes:    aluOut = '1;
                        funcZero:    aluOut = '0;
                        funcAPlusB:  aluOut = aluA + aluB + carryIn;
                        funcAMinusB: aluOut = aluA + ~aluB + carryIn;  // Carry makes it A-B
                        funcAMinus1: aluOut = aluA + '1 + carryIn;     // A-1 without carry
                        funcPassB:   aluOut = aluB;
                        default:     aluOut = '1;
                endcase
        end

        assign aluZero = (aluOut == '0);
        assign outData = resultReg;

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        opA <= '0;
                        opB <= '0;
                end else if (cmdTake) begin
                        opA <= inA;                     // Held for the whole command
                        opB <= inB;
                end
        end

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        tempA <= '0;
                        tempB <= '0;
                end else begin
                        case (uWord.aluDest)
                                destBothTemp: begin
                                        tempA <= aluOut;
                                        tempB <= aluOut;
                                end
                                destTempA: tempA <= aluOut;
                                destTempB: tempB <= aluOut;
                                default: ;              // Result or no write
                        endcase
                end
        end

        // Result starts at zero for each command, so multiply by zero
        // can go straight to the wait word
        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        resultReg <= '0;
                end else if (cmdTake) begin
                        resultReg <= '0;
                end else if (uWord.aluDest == destResult) begin
                        resultReg <= aluOut;            // Wait words never write here
                end
        end

endmodule

// File: hdl/microCpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Microprogrammed 8-bit arithmetic processor, top level
// One command in, one result out, valid/ready on both sides
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module microCpu (
        input  logic                         clk,
        input  logic                         arstN,
        input  logic                         inValid,   // Command side
        input  logic [microPkg::opW-1:0]     inOpcode,
        input  logic [microPkg::dataW-1:0]   inA,
        input  logic [microPkg::dataW-1:0]   inB,
        output logic                         inReady,
        output logic                         outValid,  // Result side
        output logic [microPkg::dataW-1:0]   outData,
        input  logic                         outReady
);
        import microPkg::*;

        microWordT  uWord;                              // Shared by sequencer and datapath
        logic [7:0] microAddr;
        logic       cmdTake;
        logic       aluZero;

        controlStore uStore (
                .microAddr (microAddr),
                .uWord     (uWord)
        );

        microSequencer uSeq (
                .clk       (clk),
                .arstN     (arstN),
                .inValid   (inValid),
                .inOpcode  (inOpcode),
                .outReady  (outReady),
                .aluZero   (aluZero),
                .uWord     (uWord),
                .microAddr (microAddr),
                .inReady   (inReady),
                .outValid  (outValid),
                .cmdTake   (cmdTake)
        );

        aluDatapath uPath (
                .clk       (clk),
                .arstN     (arstN),
                .cmdTake   (cmdTake),
                .inA       (inA),
                .inB       (inB),
                .uWord     (uWord),
                .aluZero   (aluZero),
                .outData   (outData)
        );

endmodule

// File: bench/resultChecker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Watches both handshakes of the processor, predicts each
// result from its command and counts mismatches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module resultChecker (
        input  logic                         clk,
        input  logic                         arstN,
        input  logic                         inValid,   // Command side
        input  logic                         inReady,
        input  logic [microPkg::opW-1:0]     inOpcode,
        input  logic [microPkg::dataW-1:0]   inA,
        input  logic [microPkg::dataW-1:0]   inB,
        input  logic [8*16-1:0]              testName,  // 16 characters
        input  logic                         outValid,  // Result side
        input  logic                         outReady,
        input  logic [microPkg::dataW-1:0]   outData,
        output int                           errorCount,
        output int                           takenCount
);
        import microPkg::*;

        logic [dataW-1:0] expQueue [$];                 // Predicted results, command order
        logic [8*16-1:0]  nameQueue [$];
        logic             resetChecked = 1'b0;
        logic             holdActive = 1'b0;            // Result offered but not taken
        logic [dataW-1:0] heldData;
        logic [8*16-1:0]  heldName;
        logic [dataW-1:0] expValue;
        logic [8*16-1:0]  expName;
        int               errors = 0;
        int               taken = 0;

        assign errorCount = errors;
        assign takenCount = taken;

        // Reference model of the three operations
        function automatic logic [dataW-1:0] predictResult(input logic [opW-1:0] op,
                                                           input logic [dataW-1:0] a,
                                                           input logic [dataW-1:0] b);
                logic [15:0] product;
                product = 16'(a) * 16'(b);
                case (op)
                        4'd3:    predictResult = a + b;         // ADD, wraps
                        4'd7:    predictResult = a - b;         // SUBTRACT, wraps
                        4'd12:   predictResult = product[7:0];  // MULTIPLY, low byte
                        default: predictResult = 8'hFF;         // Unknown opcode
                endcase
        endfunction

        task automatic reportValue(input logic [8*16-1:0] name, input string what,
                                   input logic [dataW-1:0] expected,
                                   input logic [dataW-1:0] actual);
                errors++;
                $display("** Error %0s (%0s): expected %h, actual %h at %0t",
                         name, what, expected, actual, $time);
        endtask

        task automatic reportFailure(input string msg);
                errors++;
                $display("Error at %0t: %0s", $time, msg);
        endtask

        // Sampled on the rising edge, inputs move on the falling edge
        always @(posedge clk) begin
                if (arstN) begin
                        if (!resetChecked) begin                // First edge out of reset
                                if (outValid !== 1'b0)
                                        reportFailure("outValid is high right after reset");
                                if (inReady !== 1'b1)
                                        reportFailure("inReady is low right after reset");
                                resetChecked = 1'b1;
                        end
                        if (holdActive) begin
                                if (outValid !== 1'b1)
                                        reportFailure("outValid dropped before result was taken");
                                else if (outData !== heldData)
                                        reportValue(heldName, "held result", heldData, outData);
                        end
                        if (inValid && inReady) begin
                                if (expQueue.size() != 0)
                                        reportFailure("command accepted while a result is pending");
                                expQueue.push_back(predictResult(inOpcode, inA, inB));
                                nameQueue.push_back(testName);
                        end
                        if (outValid && outReady) begin
                                if (expQueue.size() == 0) begin
                                        reportFailure("result taken with no command in flight");
                                end else begin
                                        expValue = expQueue.pop_front();
                                        expName = nameQueue.pop_front();
                                        if (outData !== expValue)
                                                reportValue(expName, "result", expValue, outData);
                                        taken++;
                                end
                        end
                        holdActive = outValid && !outReady;     // Must stay put next edge
                        heldData = outData;
                        heldName = (nameQueue.size() != 0) ? nameQueue[0] : testName;
                end
        end

endmodule

// File: bench/microCpuTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the microprogrammed processor, runs a table
// of commands under random result back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module microCpuTb;
        import microPkg::*;

        localparam int clkPeriod = 4;                   // ns
        localparam int numTests = 20;
        localparam int cyclesPerTest = 530;             // FF times FF plus back-pressure

        typedef struct packed {
                logic [8*16-1:0]  name;                 // Printed in error lines
                logic [opW-1:0]   opcode;
                logic [dataW-1:0] a;
                logic [dataW-1:0] b;
        } cmdEntryT;

        cmdEntryT cmdTable [numTests];
        int       fillCount = 0;
        integer   seed = 35665;                         // Back-pressure pattern
        int       randWord;

        logic             clk = 1'b0;
        logic             arstN = 1'b0;                 // In reset from time zero
        logic             inValid = 1'b0;
        logic [opW-1:0]   inOpcode = '0;
        logic [dataW-1:0] inA = '0;
        logic [dataW-1:0] inB = '0;
        logic             outReady = 1'b0;
        logic [8*16-1:0]  testName = '0;
        logic             inReady;
        logic             outValid;
        logic [dataW-1:0] outData;
        int               errorCount;
        int               takenCount;

        microCpu DUT (
                .clk      (clk),
                .arstN    (arstN),
                .inValid  (inValid),
                .inOpcode (inOpcode),
                .inA      (inA),
                .inB      (inB),
                .inReady  (inReady),
                .outValid (outValid),
                .outData  (outData),
                .outReady (outReady)
        );

        resultChecker resultCheck (
                .clk        (clk),
                .arstN      (arstN),
                .inValid    (inValid),
                .inReady    (inReady),
                .inOpcode   (inOpcode),
                .inA        (inA),
                .inB        (inB),
                .testName   (testName),
                .outValid   (outValid),
                .outReady   (outReady),
                .outData    (outData),
                .errorCount (errorCount),
                .takenCount (takenCount)
        );

        always #(clkPeriod / 2) clk = ~clk;

        // Random result back-pressure, about half the cycles
        always @(negedge clk) begin
                randWord = $random(seed);
                outReady = randWord[0];
        end

        task automatic addEntry(input logic [8*16-1:0] name, input logic [opW-1:0] op,
                                input logic [dataW-1:0] a, input logic [dataW-1:0] b);
                cmdTable[fillCount] = {name, op, a, b};
                fillCount++;
        endtask

        task automatic buildTable();
                addEntry("add basic", 4'd3, 8'h12, 8'h34);      // 46
                addEntry("add ff+01", 4'd3, 8'hFF, 8'h01);      // Wraps to 00
                addEntry("add ff+ff", 4'd3, 8'hFF, 8'hFF);
                addEntry("add zero", 4'd3, 8'h00, 8'h00);
                addEntry("sub basic", 4'd7, 8'h50, 8'h20);
                addEntry("sub 00-01", 4'd7, 8'h00, 8'h01);      // Wraps to FF
                addEntry("sub equal", 4'd7, 8'h7F, 8'h7F);
                addEntry("sub 01-ff", 4'd7, 8'h01, 8'hFF);
                addEntry("mul 06x07", 4'd12, 8'h06, 8'h07);
                addEntry("mul b zero", 4'd12, 8'h25, 8'h00);    // Skips the loop
                addEntry("mul a zero", 4'd12, 8'h00, 8'h09);
                addEntry("mul ffxff", 4'd12, 8'hFF, 8'hFF);     // Longest loop
                addEntry("mul 10x10", 4'd12, 8'h10, 8'h10);     // Low byte 00
                addEntry("mul 0dx0b", 4'd12, 8'h0D, 8'h0B);
                addEntry("unknown op0", 4'd0, 8'h12, 8'h34);
                addEntry("add after op0", 4'd3, 8'h01, 8'h02);
                addEntry("unknown opf", 4'd15, 8'hAA, 8'h55);
                addEntry("sub after opf", 4'd7, 8'h09, 8'h04);
                addEntry("unknown op8", 4'd8, 8'h00, 8'h00);
                addEntry("mul after op8", 4'd12, 8'h03, 8'h01);
        endtask

        // Called on a falling edge, returns one falling edge after acceptance
        task automatic sendCommand(input cmdEntryT entry);
                inValid = 1'b1;
                inOpcode = entry.opcode;
                inA = entry.a;
                inB = entry.b;
                testName = entry.name;
                while (inReady !== 1'b1) @(negedge clk);        // Previous result pending
                @(negedge clk);                                 // Taken on the rising edge
        endtask

        initial begin : mainFlow
                int idx;
                buildTable();
                repeat (4) @(negedge clk);
                arstN = 1'b1;
                @(negedge clk);
                for (idx = 0; idx < numTests; idx++) begin
                        sendCommand(cmdTable[idx]);
                end
                inValid = 1'b0;
                while (takenCount < numTests) @(negedge clk);   // Drain last result
                repeat (4) @(negedge clk);
                $display("Results checked: %0d of %0d, errors: %0d",
                         takenCount, numTests, errorCount);
                if (errorCount == 0 && takenCount == numTests) begin
                        $display("PASS: all tests");
                end else begin
                        $display("FAIL: see errors above");
                end
                $finish;
        end

        // Watchdog sized from the table length
        initial begin
                #(numTests * cyclesPerTest * clkPeriod);
                $display("Timeout: run did not finish in %0d cycles, %0d of %0d results taken",
                         numTests * cyclesPerTest, takenCount, numTests);
                $display("FAIL: see errors above");
                $finish;
        end

endmodule

// File: tb.f
hdl/microPkg.sv
hdl/controlStore.sv
hdl/microSequencer.sv
hdl/aluDatapath.sv
hdl/microCpu.sv
bench/resultChecker.sv
bench/microCpuTb.sv

// File: Makefile
# Verilator build and run of the processor testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f tb.f --top-module microCpuTb -Mdir obj_dir
	./obj_dir/VmicroCpuTb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "PASS: all tests" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
